//--- hdl/mutative_defines.svh
`ifndef MUTATIVE_DEFINES_SVH
`define MUTATIVE_DEFINES_SVH

// maximum associativity, fewer ways active in the smaller modes
`define MUT_WAYS         8
`define MUT_WAY_IDX_BITS 3

// set index stays fixed across all modes
`define MUT_SETS         16
`define MUT_SET_BITS     4

// 32 byte lines
`define MUT_LINE_BITS    256
`define MUT_OFFSET_BITS  5

// 32 - set - offset
`define MUT_TAG_BITS     23

`endif

//--- hdl/mutative_types.sv
`include "mutative_defines.svh"

package mutative_types;

    // cpu byte address split
    typedef struct packed {
        logic [`MUT_TAG_BITS-1:0]    tag;
        logic [`MUT_SET_BITS-1:0]    set_index;
        logic [`MUT_OFFSET_BITS-1:0] offset;
    } cache_address_t;

    typedef struct packed {
        logic                     dirty;
        logic [`MUT_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // everything one way returns for a set
    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [`MUT_TAG_BITS-1:0]  tag;
        logic [`MUT_LINE_BITS-1:0] data;
    } way_output_t;

    typedef enum logic [1:0] {
        MODE_DM,
        MODE_2WAY,
        MODE_4WAY,
        MODE_8WAY
    } mode_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL,
        FILL_WAIT,
        FLUSH_READ,
        FLUSH_WRITE
    } ctrl_state_t;

    typedef logic [`MUT_WAYS-1:0] way_mask_t;

    function automatic way_mask_t active_ways(mode_t m);
        return way_mask_t'((1 << (1 << m)) - 1); // low 1, 2, 4 or 8 ways
    endfunction

endpackage

//--- hdl/mutative_set_ram.sv
`include "mutative_defines.svh"

module mutative_set_ram #(
    parameter type entry_t        = logic,
    parameter bit  CLEAR_ON_RESET = 1'b0,
    localparam int ENTRY_BITS     = $bits(entry_t),
    localparam int MASK_BITS      = (ENTRY_BITS + 7) / 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     csb,
    input  logic                     web,
    input  logic [MASK_BITS-1:0]     wmask,
    input  logic [`MUT_SET_BITS-1:0] addr,
    input  entry_t                   din,
    output entry_t                   dout
);

    logic [ENTRY_BITS-1:0] mem [`MUT_SETS];
    logic [ENTRY_BITS-1:0] din_bits;
    logic [ENTRY_BITS-1:0] wr_bits;

    assign din_bits = din;

    // merge by byte lane, narrow entries use lane 0 as a whole
    always_comb begin
        for (int i = 0; i < ENTRY_BITS; i++) begin
            wr_bits[i] = wmask[i / 8] ? din_bits[i] : mem[addr][i];
        end
    end

    if (CLEAR_ON_RESET) begin : g_clear
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int s = 0; s < `MUT_SETS; s++) begin
                    mem[s] <= '0;
                end
                dout <= entry_t'('0);
            end else if (!csb) begin
                if (!web) mem[addr] <= wr_bits;
                else      dout      <= entry_t'(mem[addr]);
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk) begin
            if (!csb) begin
                if (!web) mem[addr] <= wr_bits;
                else      dout      <= entry_t'(mem[addr]); // dout holds across writes
            end
        end
    end

endmodule

//--- hdl/mutative_comparator.sv
`include "mutative_defines.svh"

module mutative_comparator (
    input  mutative_types::cache_address_t   cache_address,
    input  mutative_types::way_output_t      way_out [`MUT_WAYS],
    input  mutative_types::mode_t            mode,
    output logic                             hit,
    output logic [`MUT_WAY_IDX_BITS-1:0]     hit_way,
    output logic [31:0]                      rdata
);
    import mutative_types::*;

    localparam int IDX_BITS = `MUT_WAY_IDX_BITS;

    way_mask_t active;
    way_mask_t match;
    logic [7:0] word_lsb;

    assign active = active_ways(mode);

    always_comb begin
        for (int w = 0; w < `MUT_WAYS; w++) begin
            match[w] = active[w] && way_out[w].valid &&
                       (way_out[w].tag == cache_address.tag);
        end
    end

    // at most one way matches, lowest wins anyway
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `MUT_WAYS; w++) begin
            if (match[w] && !hit) begin
                hit     = 1'b1;
                hit_way = IDX_BITS'(w);
            end
        end
    end

    assign word_lsb = {cache_address.offset[4:2], 5'b00000};

    // word of the hit line, don't care on a miss
    assign rdata = way_out[hit_way].data[word_lsb +: 32];

endmodule

//--- hdl/mutative_plru.sv
`include "mutative_defines.svh"

module mutative_plru (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`MUT_SET_BITS-1:0]      set_index,
    input  logic                          touch,
    input  logic [`MUT_WAY_IDX_BITS-1:0]  touch_way,
    input  mutative_types::mode_t         mode,
    output logic [`MUT_WAY_IDX_BITS-1:0]  victim_way
);
    import mutative_types::*;

    localparam int NODES = `MUT_WAYS - 1;

    // node 0 root, 1..2 halves, 3..6 pairs
    // a set bit points the victim toward the upper child
    logic [NODES-1:0] tree [`MUT_SETS];
    logic [NODES-1:0] cur;
    logic [NODES-1:0] updated;
    logic             v2;
    logic             v1;
    logic             v0;

    assign cur = tree[set_index];

    // walk only the subtree covering the active ways
    always_comb begin
        v2 = (mode == MODE_8WAY) ? cur[0] : 1'b0;
        v1 = (mode == MODE_4WAY || mode == MODE_8WAY) ? cur[1 + v2] : 1'b0;
        v0 = (mode != MODE_DM) ? cur[3 + {v2, v1}] : 1'b0;
        victim_way = {v2, v1, v0};
    end

    // point every node on the path away from the touched way
    always_comb begin
        updated = cur;
        updated[0] = ~touch_way[2];
        updated[1 + touch_way[2]] = ~touch_way[1];
        updated[3 + touch_way[2:1]] = ~touch_way[0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `MUT_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set_index] <= updated;
        end
    end

endmodule

//--- hdl/mutative_fsm.sv
`include "mutative_defines.svh"

module mutative_fsm (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     ufp_addr,
    input  logic [3:0]                      ufp_rmask,
    input  logic [3:0]                      ufp_wmask,
    input  logic [31:0]                     ufp_wdata,
    input  logic                            hit,
    input  logic                            victim_dirty,
    input  logic                            victim_valid,
    input  logic                            dfp_resp,
    input  mutative_types::mode_t           mode_req,
    output mutative_types::cache_address_t  req,
    output logic [3:0]                      req_rmask,
    output logic [3:0]                      req_wmask,
    output logic [31:0]                     req_wdata,
    output mutative_types::way_mask_t       array_csb,
    output mutative_types::way_mask_t       array_web,
    output logic                            fill_sel,
    output logic [`MUT_SET_BITS-1:0]        ram_set,
    output logic                            plru_touch,
    output logic                            flush_active,
    output logic [`MUT_WAY_IDX_BITS-1:0]    flush_way,
    output logic                            ufp_resp,
    output logic                            dfp_read,
    output logic                            dfp_write,
    output logic                            dfp_sel,
    output mutative_types::mode_t           mode
);
    import mutative_types::*;

    ctrl_state_t              state;
    cache_address_t           cpu_addr;
    way_mask_t                lookup_ways;
    logic [`MUT_SET_BITS-1:0] flush_set;
    logic                     cpu_request;
    logic                     need_wb;
    logic                     way_done;
    logic                     set_done;

    assign cpu_addr     = ufp_addr;
    assign cpu_request  = |ufp_rmask || |ufp_wmask;
    assign lookup_ways  = active_ways(mode);
    assign need_wb      = victim_valid && victim_dirty; // victim or flush way
    assign flush_active = (state == FLUSH_READ) || (state == FLUSH_WRITE);

    // clean or invalid ways are skipped in a single cycle
    assign way_done = (state == FLUSH_WRITE) && (!need_wb || dfp_resp);
    assign set_done = way_done && (&flush_way);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            mode      <= MODE_DM;
            flush_set <= '0;
            flush_way <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_request)           state <= COMPARE;
                    else if (mode_req != mode) state <= FLUSH_READ;
                end
                COMPARE: begin
                    if (hit)          state <= IDLE;
                    else if (need_wb) state <= WRITEBACK;
                    else              state <= FILL;
                end
                WRITEBACK: if (dfp_resp) state <= FILL;
                FILL:      if (dfp_resp) state <= FILL_WAIT;
                FILL_WAIT: state <= COMPARE; // lookup again, hits now
                FLUSH_READ: state <= FLUSH_WRITE;
                FLUSH_WRITE: begin
                    if (set_done) begin
                        if (&flush_set) begin
                            mode  <= mode_req; // every way is invalid by now
                            state <= IDLE;
                        end else begin
                            state <= FLUSH_READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            // both counters wrap back to zero on their own
            if (way_done) flush_way <= flush_way + 1'b1;
            if (set_done) flush_set <= flush_set + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_request) begin
            req       <= cpu_addr;
            req_rmask <= ufp_rmask;
            req_wmask <= ufp_wmask;
            req_wdata <= ufp_wdata;
        end
    end

    always_comb begin
        array_csb  = '1;
        array_web  = '1;
        ram_set    = req.set_index;
        fill_sel   = 1'b0;
        plru_touch = 1'b0;
        ufp_resp   = 1'b0;
        dfp_read   = 1'b0;
        dfp_write  = 1'b0;
        dfp_sel    = 1'b0;
        case (state)
            IDLE: begin
                ram_set = cpu_addr.set_index; // read straight off the cpu port
                if (cpu_request) array_csb = ~lookup_ways;
            end
            COMPARE: begin
                ufp_resp   = hit;
                plru_touch = hit;
                if (hit && |req_wmask) begin
                    array_csb = ~lookup_ways;
                    array_web = ~lookup_ways;
                end
            end
            WRITEBACK: begin
                dfp_write = 1'b1;
                dfp_sel   = 1'b1;
            end
            FILL: begin
                dfp_read = 1'b1;
                fill_sel = 1'b1;
                if (dfp_resp) begin
                    array_csb = ~lookup_ways;
                    array_web = ~lookup_ways;
                end
            end
            FILL_WAIT: array_csb = ~lookup_ways;
            FLUSH_READ: begin
                ram_set   = flush_set;
                array_csb = '0;
            end
            FLUSH_WRITE: begin
                ram_set   = flush_set;
                dfp_sel   = 1'b1;
                dfp_write = need_wb;
                if (set_done) begin
                    array_csb = '0; // invalidate the whole set
                    array_web = '0;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/mutative_cache.sv
`include "mutative_defines.svh"

module mutative_cache (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [31:0]                ufp_addr,
    input  logic [3:0]                 ufp_rmask,
    input  logic [3:0]                 ufp_wmask,
    input  logic [31:0]                ufp_wdata,
    output logic [31:0]                ufp_rdata,
    output logic                       ufp_resp,

    output logic [31:0]                dfp_addr,
    output logic                       dfp_read,
    output logic                       dfp_write,
    input  logic [`MUT_LINE_BITS-1:0]  dfp_rdata,
    output logic [`MUT_LINE_BITS-1:0]  dfp_wdata,
    input  logic                       dfp_resp,

    input  mutative_types::mode_t      mode_req,
    output mutative_types::mode_t      mode
);
    import mutative_types::*;

    localparam int LINE_BYTES = `MUT_LINE_BITS / 8;
    localparam int TAG_BYTES  = ($bits(tag_entry_t) + 7) / 8;

    cache_address_t                req;
    logic [3:0]                    req_rmask;
    logic [3:0]                    req_wmask;
    logic [31:0]                   req_wdata;
    way_mask_t                     array_csb;
    way_mask_t                     array_web;
    way_mask_t                     way_web;
    logic                          fill_sel;
    logic [`MUT_SET_BITS-1:0]      ram_set;
    logic                          plru_touch;
    logic                          flush_active;
    logic                          dfp_sel;
    logic [`MUT_WAY_IDX_BITS-1:0]  flush_way;
    logic [`MUT_WAY_IDX_BITS-1:0]  hit_way;
    logic [`MUT_WAY_IDX_BITS-1:0]  victim_way;
    logic [`MUT_WAY_IDX_BITS-1:0]  sel_way;
    logic [`MUT_WAY_IDX_BITS-1:0]  target_way;
    logic                          hit;
    logic                          victim_dirty;
    logic                          victim_valid;
    logic [31:0]                   hit_word;

    logic [`MUT_LINE_BITS-1:0]     line_din;
    logic [LINE_BYTES-1:0]         line_wmask;
    tag_entry_t                    tag_din;
    logic [TAG_BYTES-1:0]          tag_wmask;
    logic                          valid_din;

    logic [`MUT_LINE_BITS-1:0]     data_q  [`MUT_WAYS];
    tag_entry_t                    tag_q   [`MUT_WAYS];
    logic                          valid_q [`MUT_WAYS];
    way_output_t                   way_out [`MUT_WAYS];

    mutative_fsm fsm (
        .clk          (clk),
        .rst          (rst),
        .ufp_addr     (ufp_addr),
        .ufp_rmask    (ufp_rmask),
        .ufp_wmask    (ufp_wmask),
        .ufp_wdata    (ufp_wdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_valid (victim_valid),
        .dfp_resp     (dfp_resp),
        .mode_req     (mode_req),
        .req          (req),
        .req_rmask    (req_rmask),
        .req_wmask    (req_wmask),
        .req_wdata    (req_wdata),
        .array_csb    (array_csb),
        .array_web    (array_web),
        .fill_sel     (fill_sel),
        .ram_set      (ram_set),
        .plru_touch   (plru_touch),
        .flush_active (flush_active),
        .flush_way    (flush_way),
        .ufp_resp     (ufp_resp),
        .dfp_read     (dfp_read),
        .dfp_write    (dfp_write),
        .dfp_sel      (dfp_sel),
        .mode         (mode)
    );

    // cpu word replicated across the line, lanes picked by the mask
    assign line_din   = fill_sel ? dfp_rdata : {(`MUT_LINE_BITS / 32){req_wdata}};
    assign line_wmask = fill_sel     ? '1 :
                        flush_active ? '0 :
                        LINE_BYTES'(req_wmask) << {req.offset[4:2], 2'b00};
    assign tag_din    = '{dirty: ~fill_sel, tag: req.tag}; // cpu writes mark dirty
    assign tag_wmask  = {TAG_BYTES{~flush_active}};
    assign valid_din  = ~flush_active;

    assign target_way = fill_sel ? victim_way : hit_way;

    always_comb begin
        for (int w = 0; w < `MUT_WAYS; w++) begin
            way_web[w] = array_web[w] | ~(flush_active | (target_way == w));
        end
    end

    for (genvar w = 0; w < `MUT_WAYS; w++) begin : g_way
        mutative_set_ram #(.entry_t(logic [`MUT_LINE_BITS-1:0])) data_ram (
            .clk (clk), .rst (rst), .csb (array_csb[w]), .web (way_web[w]),
            .wmask (line_wmask), .addr (ram_set), .din (line_din), .dout (data_q[w])
        );
        mutative_set_ram #(.entry_t(tag_entry_t)) tag_ram (
            .clk (clk), .rst (rst), .csb (array_csb[w]), .web (way_web[w]),
            .wmask (tag_wmask), .addr (ram_set), .din (tag_din), .dout (tag_q[w])
        );
        mutative_set_ram #(.entry_t(logic), .CLEAR_ON_RESET(1'b1)) valid_ram (
            .clk (clk), .rst (rst), .csb (array_csb[w]), .web (way_web[w]),
            .wmask (1'b1), .addr (ram_set), .din (valid_din), .dout (valid_q[w])
        );
    end

    always_comb begin
        for (int w = 0; w < `MUT_WAYS; w++) begin
            way_out[w] = {valid_q[w], tag_q[w], data_q[w]};
        end
    end

    mutative_comparator cmp (
        .cache_address (req),
        .way_out       (way_out),
        .mode          (mode),
        .hit           (hit),
        .hit_way       (hit_way),
        .rdata         (hit_word)
    );

    mutative_plru plru (
        .clk        (clk),
        .rst        (rst),
        .set_index  (req.set_index),
        .touch      (plru_touch),
        .touch_way  (hit_way),
        .mode       (mode),
        .victim_way (victim_way)
    );

    assign ufp_rdata = |req_rmask ? hit_word : '0;

    // flush walker borrows the victim path
    assign sel_way      = flush_active ? flush_way : victim_way;
    assign victim_valid = way_out[sel_way].valid;
    assign victim_dirty = way_out[sel_way].dirty;
    assign dfp_wdata    = way_out[sel_way].data;
    assign dfp_addr     = dfp_sel ? {way_out[sel_way].tag, ram_set, 5'b00000}
                                  : {req.tag, req.set_index, 5'b00000};

endmodule

//--- bench/mutative_cache_sva.sv
module mutative_cache_sva (
    input logic        clk,
    input logic        rst,
    input logic [3:0]  ufp_rmask,
    input logic [3:0]  ufp_wmask,
    input logic        ufp_resp,
    input logic [31:0] dfp_addr,
    input logic        dfp_read,
    input logic        dfp_write,
    input logic        dfp_resp
);

    int   fail_count = 0;
    logic cpu_request;

    assign cpu_request = |ufp_rmask || |ufp_wmask;

    one_direction: assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write))
        else begin fail_count++; $error("dfp_read and dfp_write high together"); end

    // memory side holds until the response
    read_held: assert property (@(posedge clk) disable iff (rst)
        dfp_read && !dfp_resp |=> dfp_read && $stable(dfp_addr))
        else begin fail_count++; $error("dfp read request changed before dfp_resp"); end

    write_held: assert property (@(posedge clk) disable iff (rst)
        dfp_write && !dfp_resp |=> dfp_write && $stable(dfp_addr))
        else begin fail_count++; $error("dfp write request changed before dfp_resp"); end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp)
        else begin fail_count++; $error("ufp_resp longer than one cycle"); end

    resp_with_request: assert property (@(posedge clk) disable iff (rst) ufp_resp |-> cpu_request)
        else begin fail_count++; $error("ufp_resp without a cpu request"); end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !ufp_resp && !dfp_read && !dfp_write)
        else begin fail_count++; $error("cache outputs active right after reset"); end

endmodule

bind mutative_cache mutative_cache_sva protocol_checks (
    .clk       (clk),
    .rst       (rst),
    .ufp_rmask (ufp_rmask),
    .ufp_wmask (ufp_wmask),
    .ufp_resp  (ufp_resp),
    .dfp_addr  (dfp_addr),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_resp  (dfp_resp)
);

//--- bench/mutative_cache_tb.sv
`include "mutative_defines.svh"

module mutative_cache_tb;
    import mutative_types::*;

    localparam int TIMEOUT = 5000; // cycles per cpu access, a full flush fits easily

    logic                      clk = 1'b0;
    logic                      rst;
    logic [31:0]               ufp_addr;
    logic [3:0]                ufp_rmask;
    logic [3:0]                ufp_wmask;
    logic [31:0]               ufp_wdata;
    logic [31:0]               ufp_rdata;
    logic                      ufp_resp;
    logic [31:0]               dfp_addr;
    logic                      dfp_read;
    logic                      dfp_write;
    logic [`MUT_LINE_BITS-1:0] dfp_rdata;
    logic [`MUT_LINE_BITS-1:0] dfp_wdata;
    logic                      dfp_resp;
    mode_t                     mode_req;
    mode_t                     mode;

    integer seed = 48;
    int errors = 0;
    int timeouts = 0;
    int mem_reads = 0;
    int mem_writes = 0;
    logic [`MUT_LINE_BITS-1:0] mem_lines [logic [26:0]]; // written lines only
    logic [31:0] shadow [logic [29:0]];                  // cpu view, by word address
    logic [29:0] touched [$];

    mutative_cache mutative_cache_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] memory_word(input logic [29:0] waddr);
        if (mem_lines.exists(waddr[29:3]))
            return mem_lines[waddr[29:3]][waddr[2:0] * 32 +: 32];
        return {waddr, 2'b00} ^ 32'ha5c3_0f69; // untouched memory, from the byte address
    endfunction

    function automatic logic [31:0] expected_word(input logic [29:0] waddr);
        if (shadow.exists(waddr))
            return shadow[waddr];
        return memory_word(waddr);
    endfunction

    function automatic cache_address_t make_addr(input logic [22:0] tag_value,
                                                 input logic [3:0] set_value,
                                                 input logic [2:0] word);
        return '{tag: tag_value, set_index: set_value, offset: {word, 2'b00}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic cpu_access(input cache_address_t addr, input logic [3:0] rmask,
                              input logic [3:0] wmask, input logic [31:0] wdata,
                              output int cycles);
        logic [29:0] waddr;
        logic [31:0] old_word;
        waddr = addr[31:2];
        cycles = 0;
        if (timeouts != 0)
            return;
        @(posedge clk);
        #1;
        ufp_addr = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!ufp_resp && cycles < TIMEOUT);
        if (!ufp_resp) begin
            timeouts++;
            $display("timeout, the cache never answered the request for address %h", addr);
        end else if (|rmask) begin
            check_value("ufp_rdata", expected_word(waddr) & lane_bits(rmask),
                        ufp_rdata & lane_bits(rmask));
        end
        if (ufp_resp && |wmask) begin
            old_word = expected_word(waddr);
            shadow[waddr] = (old_word & ~lane_bits(wmask)) | (wdata & lane_bits(wmask));
            touched.push_back(waddr);
        end
        @(posedge clk);
        #1;
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
    endtask

    task automatic compare_memory();
        foreach (touched[i])
            check_value("memory", shadow[touched[i]], memory_word(touched[i]));
    endtask

    task automatic change_mode(input mode_t next);
        logic [29:0] probe;
        int reads_before;
        int cycles;
        if (timeouts != 0)
            return;
        probe = touched[$];
        reads_before = mem_reads;
        @(posedge clk);
        #1 mode_req = next;
        // lands after the flush has started, so it waits for the new mode
        cpu_access(cache_address_t'({probe, 2'b00}), 4'hf, 4'h0, '0, cycles);
        check_value("mode", 32'(next), 32'(mode));
        check_value("mem_reads", reads_before + 1, mem_reads); // cached before, misses now
        compare_memory();
    endtask

    task automatic random_mix(input int count);
        cache_address_t addr;
        logic [3:0] lanes;
        int cycles;
        for (int i = 0; i < count; i++) begin
            addr = make_addr(23'h100 + 23'($unsigned($random(seed)) % 6),
                             4'($unsigned($random(seed)) % 3), 3'($random(seed)));
            lanes = 4'($random(seed));
            if (lanes == 4'h0)
                lanes = 4'hf;
            if (($random(seed) & 1) != 0)
                cpu_access(addr, 4'h0, lanes, $random(seed), cycles);
            else
                cpu_access(addr, lanes, 4'h0, '0, cycles);
        end
    endtask

    always begin : memory_model
        int delay;
        logic [26:0] line_addr;
        @(posedge clk);
        #1 dfp_resp = 1'b0;
        if (dfp_read || dfp_write) begin
            delay = 1 + int'($unsigned($random(seed)) % 4);
            repeat (delay - 1) begin
                @(posedge clk);
                #1;
            end
            line_addr = dfp_addr[31:5];
            for (int w = 0; w < 8; w++) begin
                if (dfp_write)
                    check_value("dfp_wdata", expected_word({line_addr, 3'(w)}),
                                dfp_wdata[w * 32 +: 32]);
                else
                    dfp_rdata[w * 32 +: 32] = memory_word({line_addr, 3'(w)});
            end
            if (dfp_write) begin
                mem_lines[line_addr] = dfp_wdata;
                mem_writes++;
            end else begin
                mem_reads++;
            end
            dfp_resp = 1'b1;
        end
    end

    initial begin
        cache_address_t a;
        cache_address_t b;
        int cycles;
        int reads_before;
        int writes_before;
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = 4'h0;
        ufp_wmask = 4'h0;
        ufp_wdata = '0;
        dfp_rdata = '0;
        dfp_resp = 1'b0;
        mode_req = MODE_DM;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        a = make_addr(23'h12, 4'd1, 3'd2);
        reads_before = mem_reads;
        cpu_access(a, 4'hf, 4'h0, '0, cycles);
        check_value("mem_reads", reads_before + 1, mem_reads);
        cpu_access(a, 4'hf, 4'h0, '0, cycles);
        check_value("hit cycles", 1, cycles);
        check_value("mem_reads", reads_before + 1, mem_reads);

        cpu_access(a, 4'h0, 4'b0101, 32'h1122_3344, cycles);
        cpu_access(a, 4'h0, 4'b1000, 32'hdead_beef, cycles);
        cpu_access(a, 4'hf, 4'h0, '0, cycles);
        cpu_access(a, 4'b0110, 4'h0, '0, cycles);

        // same set, other tag, direct mapped
        b = make_addr(23'h34, 4'd1, 3'd5);
        reads_before = mem_reads;
        writes_before = mem_writes;
        cpu_access(b, 4'h0, 4'hf, 32'h0bad_cafe, cycles);
        cpu_access(a, 4'hf, 4'h0, '0, cycles);
        check_value("mem_writes", writes_before + 2, mem_writes);
        cpu_access(b, 4'hf, 4'h0, '0, cycles); // victim clean this time
        check_value("mem_writes", writes_before + 2, mem_writes);
        check_value("mem_reads", reads_before + 3, mem_reads);

        change_mode(MODE_8WAY);
        for (int i = 0; i < 8; i++)
            cpu_access(make_addr(23'h40 + 23'(i), 4'd7, 3'(i)), 4'hf, 4'h0, '0, cycles);
        reads_before = mem_reads;
        writes_before = mem_writes;
        for (int i = 0; i < 8; i++) begin
            cpu_access(make_addr(23'h40 + 23'(i), 4'd7, 3'(i)), 4'hf, 4'h0, '0, cycles);
            check_value("hit cycles", 1, cycles);
        end
        check_value("mem_reads", reads_before, mem_reads);
        cpu_access(make_addr(23'h48, 4'd7, 3'd0), 4'hf, 4'h0, '0, cycles);
        check_value("mem_reads", reads_before + 1, mem_reads);
        check_value("mem_writes", writes_before, mem_writes);

        random_mix(40);
        change_mode(MODE_2WAY);
        random_mix(40);
        change_mode(MODE_4WAY);
        random_mix(40);
        change_mode(MODE_DM);
        random_mix(40);
        change_mode(MODE_8WAY);

        $display("summary: %0d data errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, mutative_cache_i.protocol_checks.fail_count);
        if (errors == 0 && timeouts == 0 && mutative_cache_i.protocol_checks.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/mutative_types.sv
hdl/mutative_set_ram.sv
hdl/mutative_comparator.sv
hdl/mutative_plru.sv
hdl/mutative_fsm.sv
hdl/mutative_cache.sv
bench/mutative_cache_sva.sv
bench/mutative_cache_tb.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := mutative_cache_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000
PASS_TEXT  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
